/* hdl/msx_cfg_pkg.sv */
package msx_cfg_pkg;

    localparam int conf_bytes     = 8;
    localparam int ram_page_bytes = 16384;   // Bytes per RAM size unit
    localparam int fifo_depth     = 4;

    typedef logic [7:0]  conf_byte_t;
    typedef logic [26:0] image_size_t;
    typedef logic [27:0] ddr_addr_t;
    typedef logic [26:0] ram_addr_t;

    // One image record, byte 0 in the top bits
    typedef struct packed {
        conf_byte_t [0:conf_bytes-1] data;
        logic                        last;   // No more data in the image
    } conf_record_t;

    typedef enum logic [7:0] {
        CONF_BLOCK = 8'h01
    } conf_t;

    typedef enum logic [7:0] {
        BLOCK_RAM    = 8'd0,
        BLOCK_MAPPER = 8'd5,
        BLOCK_DEVICE = 8'd6
    } block_t;

    typedef enum logic [2:0] {
        PATTERN_FF   = 3'd1,
        PATTERN_ZERO = 3'd2,
        PATTERN_03   = 3'd3,
        PATTERN_04   = 3'd4,
        PATTERN_05   = 3'd5
    } pattern_t;

    typedef enum logic [2:0] {
        ERR_NONE,
        ERR_BAD_MSX_CONF,
        ERR_NOT_SUPPORTED_CONF,
        ERR_NOT_SUPPORTED_BLOCK,
        ERR_DEVICE_MISSING,
        ERR_BAD_PATTERN
    } error_t;

    localparam logic [23:0] header_magic = {"M", "S", "x"};

endpackage

/* hdl/msx_layout_pkg.sv */
package msx_layout_pkg;

    localparam int layout_entries    = 64;
    localparam int max_dev_instances = 3;

    // Slot in bits 5:4, subslot in 3:2, page in 1:0
    typedef logic [5:0] slot_index_t;

    typedef logic [3:0] mapper_t;    // 0 none, 1 offset, others passed on
    typedef logic [3:0] device_t;    // 0 none
    typedef logic [1:0] dev_num_t;
    typedef logic [3:0] ram_ref_t;

    typedef struct packed {
        mapper_t  mapper;
        device_t  device;
        dev_num_t dev_num;
        ram_ref_t ram_ref;
        logic [1:0] offset;
    } slot_entry_t;

    typedef struct packed {
        slot_index_t idx;
        slot_entry_t entry;
        logic        wr_mem;     // ram_ref and offset
        logic        wr_mapper;
        logic        wr_device;  // device and dev_num
    } layout_wr_t;

endpackage

/* hdl/conf_reader.sv */
`timescale 1ns/1ps

module conf_reader (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load,
    input  logic                       abort,
    input  msx_cfg_pkg::image_size_t   image_size,
    input  msx_cfg_pkg::conf_byte_t    ddr3_dout,
    input  logic                       ddr3_ready,
    input  logic                       fifo_full,
    output msx_cfg_pkg::ddr_addr_t     ddr3_addr,
    output logic                       ddr3_rd,
    output logic                       push,
    output msx_cfg_pkg::conf_record_t  push_record
);
    import msx_cfg_pkg::*;

    logic        active;
    logic        pending;    // Read accepted, byte not yet taken
    image_size_t count;
    conf_byte_t [0:conf_bytes-1] rec_data;
    logic        rec_last;
    logic        take;

    assign take = active && !load && !abort && pending && !ddr3_rd && ddr3_ready;

    assign push_record.data = rec_data;
    assign push_record.last = rec_last;

    always_ff @(posedge clk) begin
        if (take) begin
            rec_data[count[2:0]] <= ddr3_dout;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active    <= 1'b0;
            pending   <= 1'b0;
            ddr3_rd   <= 1'b0;
            push      <= 1'b0;
            rec_last  <= 1'b0;
            ddr3_addr <= '0;
            count     <= '0;
        end else begin
            push <= 1'b0;
            if (load) begin
                active    <= 1'b1;
                pending   <= 1'b0;
                ddr3_rd   <= 1'b0;
                rec_last  <= 1'b0;
                ddr3_addr <= '0;
                count     <= '0;
            end else if (abort) begin
                active  <= 1'b0;
                pending <= 1'b0;
                ddr3_rd <= 1'b0;
            end else if (active) begin
                if (ddr3_rd && ddr3_ready) begin
                    ddr3_addr <= ddr3_addr + 1'b1;
                    ddr3_rd   <= 1'b0;
                    pending   <= 1'b1;
                end else if (take) begin
                    count   <= count + 1'b1;
                    pending <= 1'b0;
                    if (count[2:0] == 3'(conf_bytes - 1)) begin
                        push <= 1'b1;                   // Record complete
                    end
                end else if (!pending && !ddr3_rd && !push && !fifo_full) begin
                    if (count == image_size) begin
                        push     <= 1'b1;               // End marker, partial bytes dropped
                        rec_last <= 1'b1;
                        active   <= 1'b0;
                    end else begin
                        ddr3_rd <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* hdl/conf_fifo.sv */
`timescale 1ns/1ps

module conf_fifo (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       push,
    input  msx_cfg_pkg::conf_record_t  push_record,
    input  logic                       pop,
    output msx_cfg_pkg::conf_record_t  head,
    output logic                       full,
    output logic                       empty
);
    import msx_cfg_pkg::*;

    conf_record_t mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    logic [$clog2(fifo_depth)-1:0] rd_ptr;
    logic [$clog2(fifo_depth):0]   used;
    logic do_push;
    logic do_pop;

    assign full    = (used == fifo_depth);
    assign empty   = (used == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_record;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            used <= used + do_push - do_pop;
        end
    end

endmodule

/* hdl/slot_layout_table.sv */
`timescale 1ns/1ps

module slot_layout_table (
    input  logic                         clk,
    input  logic                         rst_n,
    input  msx_layout_pkg::slot_index_t  clear_idx,
    input  logic                         clear,
    input  msx_layout_pkg::layout_wr_t   wr,
    input  logic                         wr_en,
    input  msx_layout_pkg::slot_index_t  rd_addr,
    output msx_layout_pkg::slot_entry_t  rd_data,
    output logic [3:0]                   slot_expander_en
);
    import msx_layout_pkg::*;

    slot_entry_t mem [layout_entries];

    always_ff @(posedge clk) begin
        if (clear) begin
            mem[clear_idx] <= '{mapper: '0, device: '0, dev_num: '0, ram_ref: '0,
                                offset: clear_idx[1:0]};   // Identity page offset
        end else if (wr_en) begin
            if (wr.wr_mem) begin
                mem[wr.idx].ram_ref <= wr.entry.ram_ref;
                mem[wr.idx].offset  <= wr.entry.offset;
            end
            if (wr.wr_mapper) mem[wr.idx].mapper <= wr.entry.mapper;
            if (wr.wr_device) begin
                mem[wr.idx].device  <= wr.entry.device;
                mem[wr.idx].dev_num <= wr.entry.dev_num;
            end
        end
        rd_data <= mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_expander_en <= '0;
        end else if (clear && clear_idx == '0) begin
            slot_expander_en <= '0;
        end else if (wr_en && wr.idx[3:2] != 2'd0) begin
            slot_expander_en[wr.idx[5:4]] <= 1'b1;   // Subslot in use
        end
    end

endmodule

/* hdl/block_loader.sv */
`timescale 1ns/1ps

module block_loader (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load,
    input  msx_cfg_pkg::conf_record_t    head,
    input  logic                         empty,
    input  logic                         sdram_ready,
    input  msx_layout_pkg::slot_index_t  layout_rd_addr,
    output logic                         pop,
    output logic                         abort,
    output msx_cfg_pkg::ram_addr_t       ram_addr,
    output msx_cfg_pkg::conf_byte_t      ram_din,
    output logic                         ram_ce,
    output msx_layout_pkg::slot_entry_t  layout_rd_data,
    output logic [3:0]                   slot_expander_en,
    output logic                         msx_type,
    output logic                         busy,
    output logic                         done,
    output msx_cfg_pkg::error_t          error
);
    import msx_cfg_pkg::*;
    import msx_layout_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_clean,
        st_header,
        st_record,
        st_fill,
        st_layout
    } state_t;

    state_t      state;
    slot_index_t clear_idx;
    ram_ref_t    ram_ref;
    ram_addr_t   fill_left;
    ram_addr_t   fill_start;
    pattern_t    pattern;
    layout_wr_t  wr_q;
    logic [1:0]  pages_left;
    logic [max_dev_instances-1:0] dev_alloc [2**$bits(device_t)];
    block_t      blk;
    device_t     dev_type;
    dev_num_t    free_num;
    logic        free_found;
    error_t      fail_code;
    logic [8:0]  fill_pos;

    assign blk      = block_t'(head.data[2]);
    assign dev_type = device_t'(head.data[3][3:0]);
    assign pop      = !empty && (state == st_header || state == st_record);
    assign ram_ce   = (state == st_fill) && sdram_ready;
    assign fill_pos = ram_addr[8:0] - fill_start[8:0];

    always_comb begin
        free_found = 1'b0;
        free_num   = '0;
        for (int i = max_dev_instances - 1; i >= 0; i--) begin
            if (!dev_alloc[dev_type][i]) begin
                free_found = 1'b1;
                free_num   = dev_num_t'(i);   // Lowest free wins
            end
        end
    end

    always_comb begin
        fail_code = ERR_NONE;
        if (state == st_header && !empty) begin
            if (head.last || {head.data[0], head.data[1], head.data[2]} != header_magic) begin
                fail_code = ERR_BAD_MSX_CONF;
            end
        end else if (state == st_record && !empty && !head.last) begin
            if (head.data[0] != CONF_BLOCK) begin
                fail_code = ERR_NOT_SUPPORTED_CONF;
            end else begin
                case (blk)
                    BLOCK_RAM:    if (!(head.data[4] inside {[8'd1:8'd5]})) fail_code = ERR_BAD_PATTERN;
                    BLOCK_MAPPER: ;
                    BLOCK_DEVICE: if (!free_found) fail_code = ERR_DEVICE_MISSING;
                    default:      fail_code = ERR_NOT_SUPPORTED_BLOCK;
                endcase
            end
        end
    end

    always_comb begin
        case (pattern)
            PATTERN_ZERO: ram_din = 8'h00;
            PATTERN_03:   ram_din = (fill_pos[8] == fill_pos[1]) ? 8'hFF : 8'h00;
            PATTERN_04:   ram_din = (fill_pos[8] != fill_pos[0]) ? 8'hFF : 8'h00;
            PATTERN_05:   ram_din = fill_pos[7] ? 8'hFF : 8'h00;
            default:      ram_din = 8'hFF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            busy      <= 1'b0;
            done      <= 1'b0;
            abort     <= 1'b0;
            error     <= ERR_NONE;
            msx_type  <= 1'b0;
            clear_idx <= '0;
            ram_ref   <= '0;
            ram_addr  <= '0;
            fill_left <= '0;
        end else begin
            done  <= 1'b0;
            abort <= 1'b0;
            if (load) begin
                state     <= st_clean;
                busy      <= 1'b1;
                error     <= ERR_NONE;
                clear_idx <= '0;
                ram_ref   <= '0;
                ram_addr  <= '0;
            end else if (fail_code != ERR_NONE) begin
                state <= st_idle;
                busy  <= 1'b0;
                abort <= 1'b1;
                error <= fail_code;
            end else begin
                case (state)
                    st_clean: begin
                        clear_idx <= clear_idx + 1'b1;
                        if (clear_idx == slot_index_t'(layout_entries - 1)) state <= st_header;
                    end
                    st_header: begin
                        if (!empty) begin
                            msx_type <= head.data[3][0];   // 1 for MSX2
                            state    <= st_record;
                        end
                    end
                    st_record: begin
                        if (!empty) begin
                            if (head.last) begin
                                state <= st_idle;
                                busy  <= 1'b0;
                                done  <= 1'b1;
                            end else if (blk == BLOCK_RAM) begin
                                ram_ref   <= ram_ref + 1'b1;
                                fill_left <= ram_addr_t'(head.data[3] * ram_page_bytes);
                                state     <= (head.data[3] == '0) ? st_layout : st_fill;
                            end else begin
                                state <= st_layout;
                            end
                        end
                    end
                    st_fill: begin
                        if (sdram_ready) begin
                            ram_addr  <= ram_addr + 1'b1;
                            fill_left <= fill_left - 1'b1;
                            if (fill_left == ram_addr_t'(1)) state <= st_layout;
                        end
                    end
                    st_layout: begin
                        if (pages_left == 2'd0) state <= st_record;
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // Block decode and per-page write data
    always_ff @(posedge clk) begin
        if (pop && state == st_record) begin
            wr_q.idx       <= head.data[1][7:2];
            pages_left     <= head.data[1][1:0];
            wr_q.wr_mem    <= (blk == BLOCK_RAM) || (blk == BLOCK_MAPPER && head.data[4][7]);
            wr_q.wr_mapper <= (blk == BLOCK_MAPPER);
            wr_q.wr_device <= (blk == BLOCK_DEVICE);
            wr_q.entry.mapper  <= mapper_t'(head.data[3][3:0]);
            wr_q.entry.device  <= dev_type;
            wr_q.entry.dev_num <= free_num;
            // A mapper offset binds the pages to the last RAM block
            wr_q.entry.ram_ref <= (blk == BLOCK_RAM) ? ram_ref : ram_ref - 1'b1;
            wr_q.entry.offset  <= (blk == BLOCK_RAM) ? 2'd0 : head.data[4][1:0];
            pattern    <= pattern_t'(head.data[4][2:0]);
            fill_start <= ram_addr;
        end else if (state == st_layout) begin
            wr_q.idx[1:0]     <= wr_q.idx[1:0] + 2'd1;   // Page wraps mod 4
            wr_q.entry.offset <= wr_q.entry.offset + 2'd1;
            pages_left        <= pages_left - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_clean) begin
            dev_alloc[clear_idx[3:0]] <= '0;
        end else if (pop && state == st_record && blk == BLOCK_DEVICE
                     && fail_code == ERR_NONE && !head.last) begin
            dev_alloc[dev_type][free_num] <= 1'b1;
        end
    end

    slot_layout_table i_slot_layout_table (
        .clk              (clk),
        .rst_n            (rst_n),
        .clear_idx        (clear_idx),
        .clear            (state == st_clean),
        .wr               (wr_q),
        .wr_en            (state == st_layout),
        .rd_addr          (layout_rd_addr),
        .rd_data          (layout_rd_data),
        .slot_expander_en (slot_expander_en)
    );

endmodule

/* hdl/msx_conf_loader.sv */
`timescale 1ns/1ps

module msx_conf_loader (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         ioctl_download,
    input  logic [15:0]                  ioctl_index,
    input  msx_cfg_pkg::image_size_t     ioctl_addr,
    input  logic                         reload,
    input  msx_cfg_pkg::conf_byte_t      ddr3_dout,
    input  logic                         ddr3_ready,
    output msx_cfg_pkg::ddr_addr_t       ddr3_addr,
    output logic                         ddr3_rd,
    input  logic                         sdram_ready,
    output msx_cfg_pkg::ram_addr_t       ram_addr,
    output msx_cfg_pkg::conf_byte_t      ram_din,
    output logic                         ram_ce,
    input  msx_layout_pkg::slot_index_t  layout_rd_addr,
    output msx_layout_pkg::slot_entry_t  layout_rd_data,
    output logic [3:0]                   slot_expander_en,
    output logic                         msx_type,
    output logic                         busy,
    output logic                         done,
    output msx_cfg_pkg::error_t          error
);
    import msx_cfg_pkg::*;

    logic         download_q;
    logic         dl_end;
    logic         load;
    logic         abort;
    image_size_t  image_size;
    logic         push;
    logic         pop;
    logic         fifo_full;
    logic         fifo_empty;
    conf_record_t push_record;
    conf_record_t head;

    // Image download finished on index 1
    assign dl_end = download_q && !ioctl_download && ioctl_index[5:0] == 6'd1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            download_q <= 1'b0;
            load       <= 1'b0;
            image_size <= '0;
        end else begin
            download_q <= ioctl_download;
            load       <= dl_end || reload;
            if (dl_end) image_size <= ioctl_addr;
        end
    end

    conf_reader i_conf_reader (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .abort       (abort),
        .image_size  (image_size),
        .ddr3_dout   (ddr3_dout),
        .ddr3_ready  (ddr3_ready),
        .fifo_full   (fifo_full),
        .ddr3_addr   (ddr3_addr),
        .ddr3_rd     (ddr3_rd),
        .push        (push),
        .push_record (push_record)
    );

    conf_fifo i_conf_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (abort || load),   // Drop leftovers of a previous load
        .push        (push),
        .push_record (push_record),
        .pop         (pop),
        .head        (head),
        .full        (fifo_full),
        .empty       (fifo_empty)
    );

    block_loader i_block_loader (
        .clk              (clk),
        .rst_n            (rst_n),
        .load             (load),
        .head             (head),
        .empty            (fifo_empty),
        .sdram_ready      (sdram_ready),
        .layout_rd_addr   (layout_rd_addr),
        .pop              (pop),
        .abort            (abort),
        .ram_addr         (ram_addr),
        .ram_din          (ram_din),
        .ram_ce           (ram_ce),
        .layout_rd_data   (layout_rd_data),
        .slot_expander_en (slot_expander_en),
        .msx_type         (msx_type),
        .busy             (busy),
        .done             (done),
        .error            (error)
    );

endmodule

/* tb/msx_conf_loader_properties.sv */
`timescale 1ns/1ps

module msx_conf_loader_properties (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    busy,
    input logic                    done,
    input logic                    ddr3_rd,
    input logic                    ddr3_ready,
    input msx_cfg_pkg::ddr_addr_t  ddr3_addr,
    input logic                    ram_ce,
    input msx_cfg_pkg::error_t     error
);
    import msx_cfg_pkg::*;

    logic failed = 1'b0;   // Seen by the testbench top
    logic started;         // First load has begun

    always @(posedge clk) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else if (busy) begin
            started <= 1'b1;
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        !rst_n |=> !busy && !done && !ddr3_rd && !ram_ce && error == ERR_NONE)
        else begin
            $error("Outputs not idle after a reset cycle");
            failed = 1'b1;
        end

    a_idle_until_load: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !done && !ddr3_rd && !ram_ce && error == ERR_NONE)
        else begin
            $error("Outputs active before the first load");
            failed = 1'b1;
        end

    a_addr_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> ddr3_addr == '0)
        else begin
            $error("ddr3_addr not zero at the start of a load");
            failed = 1'b1;
        end

    // Abort lands in the cycle after busy falls and drops the read
    a_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
        ddr3_rd && ddr3_ready && !$fell(busy) |=> ddr3_addr == $past(ddr3_addr) + 1'b1)
        else begin
            $error("ddr3_addr did not step after an accepted read");
            failed = 1'b1;
        end

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !(ddr3_rd && ddr3_ready) |=> $stable(ddr3_addr) || $rose(busy))
        else begin
            $error("ddr3_addr moved without an accepted read");
            failed = 1'b1;
        end

    a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ddr3_rd && !ddr3_ready && !$fell(busy) |=> ddr3_rd)
        else begin
            $error("ddr3_rd dropped before it was accepted");
            failed = 1'b1;
        end

    a_done_end: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !busy && error == ERR_NONE ##1 !done)
        else begin
            $error("done is not a one cycle pulse at the end of a clean load");
            failed = 1'b1;
        end

endmodule

bind msx_conf_loader msx_conf_loader_properties i_msx_conf_loader_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .busy       (busy),
    .done       (done),
    .ddr3_rd    (ddr3_rd),
    .ddr3_ready (ddr3_ready),
    .ddr3_addr  (ddr3_addr),
    .ram_ce     (ram_ce),
    .error      (error)
);

/* tb/tb_msx_conf_loader.sv */
`timescale 1ns/1ps

module tb_msx_conf_loader;
    import msx_cfg_pkg::*;
    import msx_layout_pkg::*;

    logic        clk            = 1'b0;
    logic        rst_n          = 1'b0;
    logic        ioctl_download = 1'b0;
    logic [15:0] ioctl_index    = 16'd1;
    image_size_t ioctl_addr     = '0;
    logic        reload         = 1'b0;
    conf_byte_t  ddr3_dout      = '0;
    logic        ddr3_ready     = 1'b0;
    logic        sdram_ready    = 1'b0;
    slot_index_t layout_rd_addr = '0;
    ddr_addr_t   ddr3_addr;
    logic        ddr3_rd;
    ram_addr_t   ram_addr;
    conf_byte_t  ram_din;
    logic        ram_ce;
    slot_entry_t layout_rd_data;
    logic [3:0]  slot_expander_en;
    logic        msx_type;
    logic        busy;
    logic        done;
    error_t      error;

    logic [31:0] lfsr = 32'h05623894;
    conf_byte_t  image_mem [0:255];
    conf_byte_t  img [$];
    slot_entry_t model [layout_entries];   // Expected layout table
    logic [3:0]  model_exp;
    logic        model_msx;
    ram_ref_t    model_ref;
    int          dev_used [16];
    pattern_t    fill_pat_q [$];
    int          fill_len_q [$];
    int          img_fill;
    pattern_t    cur_pat;
    int          cur_left = 0;
    ram_addr_t   exp_addr = '0;
    ram_addr_t   blk_start;
    int          cycles = 0;
    int          limit = 2000;

    msx_conf_loader i_msx_conf_loader (.*);

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_failure($sformatf("MISMATCH at %0t: %s expected %0h, got %0h",
                                    $time, name, expected, actual));
    endtask

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic conf_byte_t expected_fill(input pattern_t pat, input logic [8:0] p);
        case (pat)
            PATTERN_FF:   return 8'hFF;
            PATTERN_ZERO: return 8'h00;
            PATTERN_03:   return (p[8] == p[1]) ? 8'hFF : 8'h00;
            PATTERN_04:   return (p[0] != p[8]) ? 8'hFF : 8'h00;
            default:      return p[7] ? 8'hFF : 8'h00;
        endcase
    endfunction

    function automatic slot_index_t page_idx(input logic [1:0] slot, sub, page, input int i);
        return {slot, sub, 2'(page + i)};   // Page wraps within the slot
    endfunction

    always @(posedge clk) begin
        logic [31:0] s;
        s = lfsr;
        ddr3_ready <= s[0];
        s = lfsr_step(s);
        sdram_ready <= s[0];
        lfsr <= lfsr_step(s);
    end

    // DDR3 byte port
    always @(posedge clk) begin
        if (ddr3_rd && ddr3_ready) begin
            ddr3_dout <= image_mem[ddr3_addr[7:0]];
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            stop_with_failure("Run exceeded its cycle limit before the loads finished");
        end
    end

    always @(negedge clk) begin
        if (i_msx_conf_loader.i_msx_conf_loader_properties.failed) begin
            stop_with_failure("A port timing assertion failed");
        end
    end

    // SDRAM write stream, one byte per ram_ce cycle
    always @(negedge clk) begin
        conf_byte_t want;
        if (ram_ce) begin
            if (cur_left == 0 && fill_pat_q.size() == 0) begin
                stop_with_failure("RAM write outside of any RAM block");
            end else begin
                if (cur_left == 0) begin
                    cur_pat   = fill_pat_q.pop_front();
                    cur_left  = fill_len_q.pop_front();
                    blk_start = exp_addr;
                end
                want = expected_fill(cur_pat, 9'(exp_addr[8:0] - blk_start[8:0]));
                assert (ram_addr == exp_addr)
                    else report_mismatch("ram_addr", exp_addr, ram_addr);
                assert (ram_din == want)
                    else report_mismatch("ram_din", want, ram_din);
                exp_addr = exp_addr + 1'b1;
                cur_left = cur_left - 1;
            end
        end
    end

    task automatic put_record(input logic [63:0] rec);
        for (int i = 0; i < conf_bytes; i++) begin
            img.push_back(rec[63 - 8 * i -: 8]);
        end
    endtask

    task automatic start_image(input logic msx2);
        img.delete();
        fill_pat_q.delete();
        fill_len_q.delete();
        img_fill  = 0;
        model_exp = '0;
        model_ref = '0;
        model_msx = msx2;
        foreach (dev_used[t]) dev_used[t] = 0;
        for (int i = 0; i < layout_entries; i++) begin
            model[i] = '0;
            model[i].offset = i[1:0];   // Cleared page maps to itself
        end
        put_record({header_magic, 7'd0, msx2, 32'd0});
    endtask

    task automatic add_ram(input logic [1:0] slot, sub, page, input int cnt,
                           input int units, input pattern_t pat);
        slot_index_t idx;
        put_record({CONF_BLOCK, slot, sub, page, 2'(cnt - 1), BLOCK_RAM, 8'(units),
                    5'd0, pat, 24'd0});
        for (int i = 0; i < cnt; i++) begin
            idx = page_idx(slot, sub, page, i);
            model[idx].ram_ref = model_ref;
            model[idx].offset  = 2'(i);
            if (sub != 2'd0) model_exp[slot] = 1'b1;
        end
        model_ref = model_ref + 1'b1;
        fill_pat_q.push_back(pat);
        fill_len_q.push_back(units * ram_page_bytes);
        img_fill += units * ram_page_bytes;
    endtask

    task automatic add_mapper(input logic [1:0] slot, sub, page, input int cnt,
                              input mapper_t mapper, input logic offs_en, input logic [1:0] offs);
        slot_index_t idx;
        put_record({CONF_BLOCK, slot, sub, page, 2'(cnt - 1), BLOCK_MAPPER, 4'd0, mapper,
                    offs_en, 5'd0, offs, 24'd0});
        for (int i = 0; i < cnt; i++) begin
            idx = page_idx(slot, sub, page, i);
            model[idx].mapper = mapper;
            if (offs_en) begin
                model[idx].ram_ref = model_ref - 1'b1;   // Most recent RAM block
                model[idx].offset  = offs + 2'(i);
            end
            if (sub != 2'd0) model_exp[slot] = 1'b1;
        end
    endtask

    task automatic add_device(input logic [1:0] slot, sub, page, input int cnt,
                              input device_t dev);
        slot_index_t idx;
        put_record({CONF_BLOCK, slot, sub, page, 2'(cnt - 1), BLOCK_DEVICE, 4'd0, dev, 32'd0});
        for (int i = 0; i < cnt; i++) begin
            idx = page_idx(slot, sub, page, i);
            model[idx].device  = dev;
            model[idx].dev_num = 2'(dev_used[dev]);
            if (sub != 2'd0) model_exp[slot] = 1'b1;
        end
        dev_used[dev]++;
    endtask

    task automatic arm_checks(input int bytes);
        exp_addr = '0;
        cur_left = 0;
        limit   += 2 * (img_fill + bytes);
    endtask

    task automatic download_image(input int trailing);
        for (int i = 0; i < trailing; i++) begin
            img.push_back(8'hA5);   // Partial record
        end
        foreach (img[i]) image_mem[i] = img[i];
        arm_checks(img.size());
        @(posedge clk);
        ioctl_download <= 1'b1;
        ioctl_addr     <= image_size_t'(img.size());
        @(posedge clk);
        ioctl_download <= 1'b0;
    endtask

    task automatic reload_image();
        img_fill = 0;
        arm_checks(img.size());
        @(posedge clk);
        reload <= 1'b1;
        @(posedge clk);
        reload <= 1'b0;
    endtask

    task automatic finish_load(input error_t want);
        do begin
            @(negedge clk);
        end while (!busy);
        do begin
            @(negedge clk);
        end while (busy);
        assert (error == want)
            else report_mismatch("error", want, error);
        assert (done == (want == ERR_NONE))
            else report_mismatch("done", want == ERR_NONE, done);
        if (want == ERR_NONE) begin
            assert (cur_left == 0 && fill_pat_q.size() == 0)
                else stop_with_failure("A RAM block got fewer writes than its size");
        end
    endtask

    task automatic check_layout();
        for (int i = 0; i <= layout_entries; i++) begin
            @(posedge clk);
            if (i < layout_entries) layout_rd_addr <= slot_index_t'(i);
            @(negedge clk);
            if (i > 0) begin
                assert (layout_rd_data == model[i - 1])
                    else report_mismatch($sformatf("layout_rd_data[%0d]", i - 1),
                                         model[i - 1], layout_rd_data);
            end
        end
        assert (slot_expander_en == model_exp)
            else report_mismatch("slot_expander_en", model_exp, slot_expander_en);
        assert (msx_type == model_msx)
            else report_mismatch("msx_type", model_msx, msx_type);
    endtask

    initial begin
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);

        start_image(1'b1);
        add_ram(2'd0, 2'd0, 2'd0, 4, 1, PATTERN_FF);
        add_ram(2'd3, 2'd1, 2'd0, 2, 1, PATTERN_ZERO);
        add_ram(2'd3, 2'd1, 2'd2, 2, 1, PATTERN_03);
        add_ram(2'd2, 2'd0, 2'd1, 1, 1, PATTERN_04);
        add_ram(2'd3, 2'd2, 2'd3, 2, 1, PATTERN_05);   // Pages 3 and 0
        add_mapper(2'd1, 2'd0, 2'd1, 2, 4'd4, 1'b0, 2'd0);
        add_mapper(2'd2, 2'd0, 2'd1, 1, 4'd1, 1'b1, 2'd2);
        add_device(2'd1, 2'd1, 2'd0, 1, 4'd3);
        add_device(2'd1, 2'd1, 2'd1, 1, 4'd3);
        add_device(2'd1, 2'd2, 2'd2, 2, 4'd3);
        add_device(2'd0, 2'd3, 2'd2, 1, 4'd5);
        download_image(3);
        finish_load(ERR_NONE);
        check_layout();

        // Same image with a broken magic
        image_mem[0] = 8'h00;
        reload_image();
        finish_load(ERR_BAD_MSX_CONF);

        start_image(1'b0);
        repeat (4) add_device(2'd0, 2'd0, 2'd0, 1, 4'd7);
        download_image(0);
        finish_load(ERR_DEVICE_MISSING);

        start_image(1'b0);
        add_mapper(2'd0, 2'd0, 2'd0, 1, 4'd2, 1'b0, 2'd0);
        add_device(2'd2, 2'd0, 2'd3, 1, 4'd3);
        download_image(0);
        finish_load(ERR_NONE);
        check_layout();

        if (i_msx_conf_loader.i_msx_conf_loader_properties.failed) begin
            stop_with_failure("A port timing assertion failed");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

/* msx_conf_loader.f */
hdl/msx_cfg_pkg.sv
hdl/msx_layout_pkg.sv
hdl/conf_reader.sv
hdl/conf_fifo.sv
hdl/slot_layout_table.sv
hdl/block_loader.sv
hdl/msx_conf_loader.sv
tb/msx_conf_loader_properties.sv
tb/tb_msx_conf_loader.sv

/* Bender.yml */
package:
  name: msx_conf_loader

sources:
  - files:
      - hdl/msx_cfg_pkg.sv
      - hdl/msx_layout_pkg.sv
      - hdl/conf_reader.sv
      - hdl/conf_fifo.sv
      - hdl/slot_layout_table.sv
      - hdl/block_loader.sv
      - hdl/msx_conf_loader.sv
  - target: simulation
    files:
      - tb/msx_conf_loader_properties.sv
      - tb/tb_msx_conf_loader.sv
